//--- Bender.yml
package:
  name: ddc

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/ddc_cfg_pkg.sv
      - rtl/ddc_dsp_pkg.sv
      - rtl/ddc_nco_mixer.sv
      - rtl/ddc_tap_buffer.sv
      - rtl/ddc_fir_decimator.sv
      - rtl/ddc.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_ddc.sv

//--- include/ddc_sincos_lut.svh
// Entry a holds sin(a * pi / 128) scaled by 32767
// Other quadrants come from mirroring the address and flipping the sign
localparam logic signed [TRIG_WIDTH-1:0] SINE_LUT [LUT_DEPTH] = '{
    // 0 .. 15
        0,   804,  1608,  2410,
     3212,  4011,  4808,  5602,
     6393,  7179,  7962,  8739,
     9512, 10278, 11039, 11793,
    // 16 .. 31
    12539, 13279, 14010, 14732,
    15446, 16151, 16846, 17530,
    18204, 18868, 19519, 20159,
    20787, 21403, 22005, 22594,
    // 32 .. 47
    23170, 23732, 24279, 24812,
    25329, 25832, 26319, 26790,
    27245, 27684, 28105, 28510,
    28898, 29268, 29621, 29956,
    // 48 .. 63
    30273, 30571, 30852, 31113,
    31356, 31580, 31785, 31971,
    32138, 32285, 32412, 32521,
    32609, 32678, 32728, 32757
};

//--- list.f
+incdir+include
rtl/ddc_cfg_pkg.sv
rtl/ddc_dsp_pkg.sv
rtl/ddc_nco_mixer.sv
rtl/ddc_tap_buffer.sv
rtl/ddc_fir_decimator.sv
rtl/ddc.sv
sim/tb_ddc.sv

//--- rtl/ddc.sv
`timescale 1ns/1ps

module ddc
    import ddc_cfg_pkg::*;
    import ddc_dsp_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   en_i,
    input  round_mode_t            round_type_i,
    input  logic [DEC_WIDTH-1:0]   decimation_i,
    input  logic [PHASE_WIDTH-1:0] phase_inc_i,
    input  logic [PHASE_WIDTH-1:0] phase_offset_i,
    input  logic                   tvalid_i,
    input  iq_t                    tdata_i,
    output logic                   tvalid_o,
    output iq_t                    tdata_o
);

    logic     mix_valid;
    iq_t      mix_data;
    logic     hist_valid;
    iq_hist_t hist_data;

    // ======================================================================
    // NCO and mixer, two cycles
    // ======================================================================

    ddc_nco_mixer u_mixer (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .en_i          (en_i),
        .round_type_i  (round_type_i),
        .phase_inc_i   (phase_inc_i),
        .phase_offset_i(phase_offset_i),
        .valid_i       (tvalid_i),
        .data_i        (tdata_i),
        .valid_o       (mix_valid),
        .data_o        (mix_data)
    );

    ddc_tap_buffer u_tap_buffer (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .en_i   (en_i),
        .valid_i(mix_valid),
        .data_i (mix_data),
        .valid_o(hist_valid),
        .hist_o (hist_data)
    );

    // ======================================================================
    // Decimating filter
    // ======================================================================

    ddc_fir_decimator u_fir (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .en_i        (en_i),
        .round_type_i(round_type_i),
        .decimation_i(decimation_i),
        .valid_i     (hist_valid),
        .hist_i      (hist_data),
        .valid_o     (tvalid_o),
        .data_o      (tdata_o)
    );

endmodule

//--- rtl/ddc_cfg_pkg.sv
package ddc_cfg_pkg;

    // ======================================================================
    // Datapath sizes
    // ======================================================================

    localparam int DATA_WIDTH = 16;     // One I or Q component
    localparam int COEF_WIDTH = 18;     // Signed filter coefficient
    localparam int TRIG_WIDTH = 16;     // Signed sine/cosine, full scale 32767

    // ======================================================================
    // Oscillator
    // ======================================================================

    localparam int PHASE_WIDTH = 14;

    // Top phase bits select quadrant, next ones address the table
    localparam int QUAD_WIDTH     = 2;
    localparam int LUT_ADDR_WIDTH = 6;
    localparam int LUT_DEPTH      = 2 ** LUT_ADDR_WIDTH;

    // ======================================================================
    // Filter and rate
    // ======================================================================

    localparam int TAP_NUM = 8;

    // Decimation factor, 0 behaves like 1
    localparam int DEC_WIDTH = 4;

endpackage

//--- rtl/ddc_dsp_pkg.sv
package ddc_dsp_pkg;

    import ddc_cfg_pkg::*;

    typedef logic signed [DATA_WIDTH-1:0] sample_t;

    typedef struct packed {
        sample_t i;
        sample_t q;
    } iq_t;

    // Entry 0 holds the newest sample
    typedef iq_t [TAP_NUM-1:0] iq_hist_t;

    typedef enum logic {
        ROUND_TRUNC   = 1'b0,
        ROUND_HALF_UP = 1'b1
    } round_mode_t;

    // ======================================================================
    // Scaling
    // ======================================================================

    localparam int MIX_SHIFT = 15;
    localparam int FIR_SHIFT = 17;

    // Wide enough for the full filter sum
    localparam int ACC_WIDTH = 40;

    localparam logic signed [ACC_WIDTH-1:0] SAT_MAX = (2 ** (DATA_WIDTH - 1)) - 1;
    localparam logic signed [ACC_WIDTH-1:0] SAT_MIN = -(2 ** (DATA_WIDTH - 1));

    // Symmetric low-pass, taps sum to 2**17 for unity DC gain
    localparam logic signed [COEF_WIDTH-1:0] FIR_COEF [TAP_NUM] = '{
        2048, 8192, 20480, 34816, 34816, 20480, 8192, 2048
    };

    // Shift right with optional half-LSB bias, then clip to sample_t
    function automatic sample_t round_sat(
        input logic signed [ACC_WIDTH-1:0] value,
        input int unsigned                 shift,
        input round_mode_t                 mode
    );
        logic signed [ACC_WIDTH-1:0] half;
        logic signed [ACC_WIDTH-1:0] shifted;
        half = ACC_WIDTH'(1) << (shift - 1);
        if (mode == ROUND_HALF_UP) begin
            shifted = (value + half) >>> shift;
        end else begin
            shifted = value >>> shift;
        end
        if (shifted > SAT_MAX) begin
            return sample_t'(SAT_MAX);
        end
        if (shifted < SAT_MIN) begin
            return sample_t'(SAT_MIN);
        end
        return sample_t'(shifted);
    endfunction

endpackage

//--- rtl/ddc_fir_decimator.sv
`timescale 1ns/1ps

module ddc_fir_decimator
    import ddc_cfg_pkg::*;
    import ddc_dsp_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 en_i,
    input  round_mode_t          round_type_i,
    input  logic [DEC_WIDTH-1:0] decimation_i,
    input  logic                 valid_i,
    input  iq_hist_t             hist_i,
    output logic                 valid_o,
    output iq_t                  data_o
);

    // ======================================================================
    // Decimation counter
    // ======================================================================

    logic [DEC_WIDTH-1:0] dec_cnt_q;
    logic [DEC_WIDTH-1:0] dec_eff;
    logic [DEC_WIDTH:0]   cnt_next;
    logic                 group_done;

    assign dec_eff    = (decimation_i == '0) ? DEC_WIDTH'(1) : decimation_i;
    assign cnt_next   = dec_cnt_q + 1'b1;
    assign group_done = (cnt_next >= {1'b0, dec_eff});   // Also covers a factor lowered mid-group

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            dec_cnt_q <= '0;
        end else if (en_i && valid_i) begin
            if (group_done) begin
                dec_cnt_q <= '0;
            end else begin
                dec_cnt_q <= cnt_next[DEC_WIDTH-1:0];
            end
        end
    end

    // ======================================================================
    // Multiply-accumulate
    // ======================================================================

    logic signed [ACC_WIDTH-1:0] acc_i;
    logic signed [ACC_WIDTH-1:0] acc_q;

    // All taps in parallel, one window per cycle
    always_comb begin
        acc_i = '0;
        acc_q = '0;
        for (int k = 0; k < TAP_NUM; k++) begin
            acc_i = acc_i + hist_i[k].i * FIR_COEF[k];
            acc_q = acc_q + hist_i[k].q * FIR_COEF[k];
        end
    end

    // ======================================================================
    // Output register
    // ======================================================================

    logic out_valid_q;
    iq_t  out_data_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            out_valid_q <= 1'b0;
        end else if (en_i) begin
            out_valid_q <= valid_i & group_done;
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_i && valid_i && group_done) begin
            out_data_q.i <= round_sat(acc_i, FIR_SHIFT, round_type_i);
            out_data_q.q <= round_sat(acc_q, FIR_SHIFT, round_type_i);
        end
    end

    assign valid_o = out_valid_q & en_i;    // Held result shows again once enabled
    assign data_o  = out_data_q;

endmodule

//--- rtl/ddc_nco_mixer.sv
`timescale 1ns/1ps

module ddc_nco_mixer
    import ddc_cfg_pkg::*;
    import ddc_dsp_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   en_i,
    input  round_mode_t            round_type_i,
    input  logic [PHASE_WIDTH-1:0] phase_inc_i,
    input  logic [PHASE_WIDTH-1:0] phase_offset_i,
    input  logic                   valid_i,
    input  iq_t                    data_i,
    output logic                   valid_o,
    output iq_t                    data_o
);

    `include "ddc_sincos_lut.svh"

    localparam logic signed [TRIG_WIDTH-1:0] TRIG_MAX = (2 ** (TRIG_WIDTH - 1)) - 1;
    localparam int ADDR_MSB = PHASE_WIDTH - QUAD_WIDTH - 1;

    // Quarter-wave lookup, odd quadrants read the table backwards
    function automatic logic signed [TRIG_WIDTH-1:0] quarter_sine(
        input logic [QUAD_WIDTH-1:0]     quad,
        input logic [LUT_ADDR_WIDTH-1:0] addr
    );
        logic [LUT_ADDR_WIDTH-1:0]    mirror;
        logic signed [TRIG_WIDTH-1:0] mag;
        mirror = ~addr + 1'b1;
        if (quad[0]) begin
            mag = (addr == '0) ? TRIG_MAX : SINE_LUT[mirror];   // Peak is not in table
        end else begin
            mag = SINE_LUT[addr];
        end
        return quad[1] ? -mag : mag;
    endfunction

    // ======================================================================
    // Phase and lookup
    // ======================================================================

    logic [PHASE_WIDTH-1:0]    phase_acc_q;
    logic [PHASE_WIDTH-1:0]    phase;
    logic [QUAD_WIDTH-1:0]     quad;
    logic [LUT_ADDR_WIDTH-1:0] addr;

    assign phase = phase_acc_q + phase_offset_i;
    assign quad  = phase[PHASE_WIDTH-1 -: QUAD_WIDTH];
    assign addr  = phase[ADDR_MSB -: LUT_ADDR_WIDTH];

    logic                         s1_valid_q;
    iq_t                          s1_data_q;
    logic signed [TRIG_WIDTH-1:0] s1_sin_q;
    logic signed [TRIG_WIDTH-1:0] s1_cos_q;

    logic s2_valid_q;
    iq_t  s2_data_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            phase_acc_q <= '0;
            s1_valid_q  <= 1'b0;
            s2_valid_q  <= 1'b0;
        end else if (en_i) begin
            s1_valid_q <= valid_i;
            s2_valid_q <= s1_valid_q;
            if (valid_i) begin
                phase_acc_q <= phase_acc_q + phase_inc_i;   // Next sample's phase
            end
        end
    end

    // ======================================================================
    // Rotation
    // ======================================================================

    logic signed [2*DATA_WIDTH:0] rot_i;
    logic signed [2*DATA_WIDTH:0] rot_q;

    assign rot_i = s1_data_q.i * s1_cos_q + s1_data_q.q * s1_sin_q;
    assign rot_q = s1_data_q.q * s1_cos_q - s1_data_q.i * s1_sin_q;

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (valid_i) begin
                s1_data_q <= data_i;
                s1_sin_q  <= quarter_sine(quad, addr);
                s1_cos_q  <= quarter_sine(quad + 1'b1, addr);   // Cos leads by a quadrant
            end
            if (s1_valid_q) begin
                s2_data_q.i <= round_sat(rot_i, MIX_SHIFT, round_type_i);
                s2_data_q.q <= round_sat(rot_q, MIX_SHIFT, round_type_i);
            end
        end
    end

    assign valid_o = s2_valid_q & en_i;
    assign data_o  = s2_data_q;

endmodule

//--- rtl/ddc_tap_buffer.sv
`timescale 1ns/1ps

module ddc_tap_buffer
    import ddc_cfg_pkg::*;
    import ddc_dsp_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     en_i,
    input  logic     valid_i,
    input  iq_t      data_i,
    output logic     valid_o,
    output iq_hist_t hist_o
);

    // ======================================================================
    // Tap history
    // ======================================================================

    iq_hist_t hist_q;
    logic     valid_q;

    // Shift in one sample per accept
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            hist_q  <= '0;
            valid_q <= 1'b0;
        end else if (en_i) begin
            valid_q <= valid_i;     // One strobe per new window
            if (valid_i) begin
                hist_q <= {hist_q[TAP_NUM-2:0], data_i};   // Oldest entry drops out
            end
        end
    end

    assign valid_o = valid_q & en_i;
    assign hist_o  = hist_q;

endmodule

//--- sim/tb_ddc.sv
`timescale 1ns/1ps

module tb_ddc
    import ddc_cfg_pkg::*;
    import ddc_dsp_pkg::*;
();

    `include "ddc_sincos_lut.svh"

    typedef enum int {
        KIND_DC,
        KIND_ALT,
        KIND_RAND
    } kind_t;

    typedef struct {
        string       name;
        int          dec;
        int          inc;
        int          offset;
        round_mode_t rnd;
        logic [15:0] gaps;      // Set bit drops en_i in that cycle
        int          samples;
        kind_t       kind;
        int          reset_at;  // 0 for no reset inside the stream
    } entry_t;

    localparam int     NUM_ENTRIES = 9;
    localparam int     POOL_SIZE   = 64;
    localparam int     OUT_DELAY   = 3;     // Enabled edges from accept to visible result
    localparam longint SMAX        = (longint'(1) <<< (DATA_WIDTH - 1)) - 1;
    localparam longint SMIN        = -(longint'(1) <<< (DATA_WIDTH - 1));

    logic                   clk_i = 1'b0;
    logic                   rst_n_i;
    logic                   en_i;
    round_mode_t            round_type_i;
    logic [DEC_WIDTH-1:0]   decimation_i;
    logic [PHASE_WIDTH-1:0] phase_inc_i;
    logic [PHASE_WIDTH-1:0] phase_offset_i;
    logic                   tvalid_i;
    iq_t                    tdata_i;
    logic                   tvalid_o;
    iq_t                    tdata_o;

    entry_t tbl [NUM_ENTRIES];
    iq_t    pool [POOL_SIZE];
    entry_t cur;
    bit     cur_identity;

    int  phase_m;
    iq_t hist_m [TAP_NUM];
    int  grp_m;
    int  accept_cnt;
    int  en_edges;
    int  out_count;
    int  cycle_cnt;
    int  timeout_limit;
    iq_t exp_q [$];
    int  due_q [$];

    always #10 clk_i = ~clk_i;

    ddc u_dut (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .en_i          (en_i),
        .round_type_i  (round_type_i),
        .decimation_i  (decimation_i),
        .phase_inc_i   (phase_inc_i),
        .phase_offset_i(phase_offset_i),
        .tvalid_i      (tvalid_i),
        .tdata_i       (tdata_i),
        .tvalid_o      (tvalid_o),
        .tdata_o       (tdata_o)
    );

    // ======================================================================
    // Reference model
    // ======================================================================

    // idx counts 256 steps per turn
    function automatic longint sine_at(input int idx);
        int     quad;
        int     a;
        longint mag;
        quad = (idx >> LUT_ADDR_WIDTH) % 4;
        a    = idx % LUT_DEPTH;
        if (quad == 0 || quad == 2) begin
            mag = SINE_LUT[a];
        end else if (a == 0) begin
            mag = 32767;        // Peak of the wave
        end else begin
            mag = SINE_LUT[LUT_DEPTH - a];
        end
        return (quad >= 2) ? -mag : mag;
    endfunction

    function automatic sample_t scale_round(input longint value, input int shift,
                                            input round_mode_t mode);
        longint r;
        r = value;
        if (mode == ROUND_HALF_UP) begin
            r = r + (longint'(1) <<< (shift - 1));
        end
        r = r >>> shift;
        if (r > SMAX) begin
            r = SMAX;
        end else if (r < SMIN) begin
            r = SMIN;
        end
        return sample_t'(r);
    endfunction

    task automatic model_reset();
        phase_m    = 0;
        grp_m      = 0;
        accept_cnt = 0;
        foreach (hist_m[k]) begin
            hist_m[k] = '0;
        end
        exp_q.delete();
        due_q.delete();
    endtask

    task automatic model_accept(input iq_t x);
        int     idx;
        int     k;
        int     dec_eff;
        longint s;
        longint c;
        longint ri;
        longint rq;
        longint ai;
        longint aq;
        iq_t    m;
        iq_t    y;
        idx = ((phase_m + cur.offset) % (1 << PHASE_WIDTH))
              >> (PHASE_WIDTH - QUAD_WIDTH - LUT_ADDR_WIDTH);
        s   = sine_at(idx);
        c   = sine_at((idx + LUT_DEPTH) % (4 * LUT_DEPTH));   // Quarter turn ahead
        ri  = longint'(x.i) * c + longint'(x.q) * s;
        rq  = longint'(x.q) * c - longint'(x.i) * s;
        m.i = scale_round(ri, MIX_SHIFT, cur.rnd);
        m.q = scale_round(rq, MIX_SHIFT, cur.rnd);
        phase_m = (phase_m + cur.inc) % (1 << PHASE_WIDTH);
        for (k = TAP_NUM - 1; k > 0; k--) begin
            hist_m[k] = hist_m[k-1];
        end
        hist_m[0] = m;
        accept_cnt++;
        grp_m++;
        dec_eff = (cur.dec == 0) ? 1 : cur.dec;
        if (grp_m >= dec_eff) begin
            grp_m = 0;
            ai    = 0;
            aq    = 0;
            for (k = 0; k < TAP_NUM; k++) begin
                ai = ai + longint'(hist_m[k].i) * longint'(FIR_COEF[k]);
                aq = aq + longint'(hist_m[k].q) * longint'(FIR_COEF[k]);
            end
            y.i = scale_round(ai, FIR_SHIFT, cur.rnd);
            y.q = scale_round(aq, FIR_SHIFT, cur.rnd);
            if (cur_identity && accept_cnt >= TAP_NUM) begin
                y = x;      // Full window of DC passes unchanged
            end
            exp_q.push_back(y);
            due_q.push_back(en_edges + OUT_DELAY);
        end
    endtask

    // Model steps on each enabled clock edge
    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt > timeout_limit) begin
            $display("Timeout after %0d cycles, the run did not finish in time", cycle_cnt);
            stop_on_failure();
        end else if (!rst_n_i) begin
            model_reset();
        end else if (en_i) begin
            en_edges++;
            if (tvalid_i) begin
                model_accept(tdata_i);
            end
        end
    end

    // ======================================================================
    // Checks
    // ======================================================================

    task automatic stop_on_failure();
        $display("Test failed");
        $fatal(1, "Simulation stopped at %0t", $time);
    endtask

    task automatic compare_iq(input string name, input iq_t exp_v, input iq_t act_v);
        if (act_v !== exp_v) begin
            $display("** Error in test %s: expected i=%0d q=%0d, actual i=%0d q=%0d",
                     name, exp_v.i, exp_v.q, act_v.i, act_v.q);
            stop_on_failure();
        end
    endtask

    task automatic compare_count(input string name, input int exp_v, input int act_v);
        if (act_v != exp_v) begin
            $display("** Error in test %s: expected %0d outputs, actual %0d outputs",
                     name, exp_v, act_v);
            stop_on_failure();
        end
    endtask

    always @(negedge clk_i) begin : monitor
        bit expect_now;
        if (rst_n_i) begin
            expect_now = en_i && (due_q.size() > 0) && (due_q[0] == en_edges);
            if (tvalid_o !== expect_now) begin
                if (expect_now) begin
                    $display("Test %s: an expected output never showed up", cur.name);
                end else begin
                    $display("Test %s: tvalid_o rose when no output was due", cur.name);
                end
                stop_on_failure();
            end else if (expect_now) begin
                compare_iq(cur.name, exp_q.pop_front(), tdata_o);
                void'(due_q.pop_front());
                out_count++;
            end
        end
    end

    // ======================================================================
    // Stimulus
    // ======================================================================

    task automatic next_cycle();
        @(posedge clk_i);
        #2;
    endtask

    task automatic apply_reset(input int cycles);
        rst_n_i  = 1'b0;
        en_i     = 1'b0;
        tvalid_i = 1'b0;
        repeat (cycles) next_cycle();
        rst_n_i   = 1'b1;
        out_count = 0;
    endtask

    function automatic iq_t sample_for(input kind_t kind, input int s);
        iq_t x;
        case (kind)
            KIND_DC: begin
                x.i = 12000;
                x.q = -3000;
            end
            KIND_ALT: begin
                x.i = s[0] ? sample_t'(SMIN) : sample_t'(SMAX);
                x.q = x.i;
            end
            default: begin
                x = pool[s % POOL_SIZE];
            end
        endcase
        return x;
    endfunction

    task automatic set_entry(input int idx, input string name, input int dec, input int inc,
                             input int offset, input round_mode_t rnd, input logic [15:0] gaps,
                             input int samples, input kind_t kind, input int reset_at);
        tbl[idx].name     = name;
        tbl[idx].dec      = dec;
        tbl[idx].inc      = inc;
        tbl[idx].offset   = offset;
        tbl[idx].rnd      = rnd;
        tbl[idx].gaps     = gaps;
        tbl[idx].samples  = samples;
        tbl[idx].kind     = kind;
        tbl[idx].reset_at = reset_at;
    endtask

    task automatic load_table();
        set_entry(0, "dc_unity",       1,    0,    0, ROUND_HALF_UP, 16'h0000, 16, KIND_DC,   0);
        set_entry(1, "dec_three",      3,    0,    0, ROUND_TRUNC,   16'h0000, 20, KIND_RAND, 0);
        set_entry(2, "dec_zero",       0,    0,    0, ROUND_TRUNC,   16'h0000, 12, KIND_DC,   0);
        set_entry(3, "rotate_trunc",   2, 1000,  300, ROUND_TRUNC,   16'h0000, 32, KIND_RAND, 0);
        set_entry(4, "rotate_half_up", 2, 1000,  300, ROUND_HALF_UP, 16'h0000, 32, KIND_RAND, 0);
        set_entry(5, "sat_trunc",      1,    0, 2048, ROUND_TRUNC,   16'h0000, 16, KIND_ALT,  0);
        set_entry(6, "sat_half_up",    1,    0, 2048, ROUND_HALF_UP, 16'h0000, 16, KIND_ALT,  0);
        set_entry(7, "en_gaps",        3,  517, 9000, ROUND_HALF_UP, 16'h0C30, 30, KIND_RAND, 0);
        set_entry(8, "reset_mid",      2, 2345,  100, ROUND_TRUNC,   16'h0000, 24, KIND_RAND, 10);
    endtask

    task automatic run_entry(input int e);
        int s;
        int cyc;
        int dec_eff;
        bit gap;
        bit did_reset;
        cur = tbl[e];
        cur_identity = (cur.kind == KIND_DC) && (cur.inc == 0) && (cur.offset == 0)
                       && (cur.rnd == ROUND_HALF_UP);
        dec_eff        = (cur.dec == 0) ? 1 : cur.dec;
        round_type_i   = cur.rnd;
        decimation_i   = DEC_WIDTH'(cur.dec);
        phase_inc_i    = PHASE_WIDTH'(cur.inc);
        phase_offset_i = PHASE_WIDTH'(cur.offset);
        apply_reset(5);
        s         = 0;
        cyc       = 0;
        did_reset = 1'b0;
        while (s < cur.samples) begin
            if (cur.reset_at != 0 && s == cur.reset_at && !did_reset) begin
                apply_reset(5);
                did_reset = 1'b1;
            end
            gap      = cur.gaps[cyc % 16];
            en_i     = !gap;
            tvalid_i = 1'b1;        // Held high through gaps as well
            tdata_i  = sample_for(cur.kind, s);
            next_cycle();
            if (!gap) begin
                s++;
            end
            cyc++;
        end
        en_i     = 1'b1;
        tvalid_i = 1'b0;
        while (exp_q.size() > 0) begin
            next_cycle();
        end
        repeat (4) next_cycle();    // Catch a late extra strobe
        compare_count(cur.name, (cur.samples - cur.reset_at) / dec_eff, out_count);
    endtask

    initial begin : stimulus
        int e;
        int j;
        rst_n_i        = 1'b0;
        en_i           = 1'b0;
        round_type_i   = ROUND_TRUNC;
        decimation_i   = '0;
        phase_inc_i    = '0;
        phase_offset_i = '0;
        tvalid_i       = 1'b0;
        tdata_i        = '0;
        cycle_cnt      = 0;
        en_edges       = 0;
        out_count      = 0;
        model_reset();
        void'($urandom(92440));
        for (j = 0; j < POOL_SIZE; j++) begin
            pool[j].i = sample_t'($urandom);
            pool[j].q = sample_t'($urandom);
        end
        load_table();
        timeout_limit = 100;
        for (e = 0; e < NUM_ENTRIES; e++) begin
            timeout_limit += tbl[e].samples * 2 + 10;
        end
        next_cycle();
        for (e = 0; e < NUM_ENTRIES; e++) begin
            run_entry(e);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule
